// File: ads868x_ctrl.f
ads868x_pkg.sv
ads868x_spi_if.sv
ads868x_regs.sv
ads868x_cmd_seq.sv
ads868x_spi_shifter.sv
ads868x_ctrl.sv
ads868x_adc_model.sv
ads868x_checker.sv
tb_ads868x_ctrl.sv

// File: Makefile
# Verilator simulation of the ADS868x controller

VERILATOR ?= verilator
TOP       ?= tb_ads868x_ctrl
FILELIST  ?= ads868x_ctrl.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "all tests passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb_ads868x_ctrl.sv
// ADS868x controller testbench
`timescale 1ns/1ps
`default_nettype none

module tb_ads868x_ctrl import ads868x_pkg::*; ();

    typedef enum int {op_wr, op_rd, op_flag, op_pin, op_quiet} op_t;

    // one table row, for op_pin the address names the pin to check
    typedef struct {
        op_t               op;
        logic [addr_w-1:0] addr;
        logic [be_w-1:0]   be;
        logic [data_w-1:0] data;
        logic [data_w-1:0] exp;
    } step_t;

    logic                 clk;
    logic                 rst;
    logic [addr_w-1:0]    wr_addr;
    logic                 wr_req;
    logic [be_w-1:0]      wr_be;
    logic [data_w-1:0]    wr_data;
    logic                 wr_ack;
    logic [addr_w-1:0]    rd_addr;
    logic                 rd_req;
    logic [data_w-1:0]    rd_data;
    logic                 rd_ack;
    logic                 sclk;
    logic                 cs_n;
    logic                 mosi;
    logic                 miso;
    logic                 rst_pd_n;
    logic [mux_sel_w-1:0] mux_sel;
    logic [mux_en_w-1:0]  mux_en;

    // checker and converter model controls
    int                   test_num;
    logic                 check_rd;
    logic                 check_pin;
    logic [addr_w-1:0]    pin_sel;
    logic [data_w-1:0]    exp_data;
    logic                 quiet;
    logic                 fault;
    logic                 finish_run;
    int                   fail_count;
    tx_bytes_t            frame_bytes;

    step_t                steps[$];
    logic [31:0]          rng;

    always #10 clk = ~clk;

    ads868x_ctrl DUT (.*);

    ads868x_adc_model adc (.*);

    ads868x_checker chk (.*);

    // ----------------------------------------------------------------------
    // helpers
    // ----------------------------------------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [data_w-1:0] next_random();
        rng = xorshift32(rng);
        return rng;
    endfunction

    // register contents after a write with partial byte enables
    function automatic logic [data_w-1:0] merge_bytes(input logic [data_w-1:0] old_word,
                                                     input logic [data_w-1:0] new_word,
                                                     input logic [be_w-1:0] be);
        logic [data_w-1:0] result;
        result = old_word;
        for (int i = 0; i < be_w; i++) begin
            if (be[i]) begin
                result[i*8 +: 8] = new_word[i*8 +: 8];
            end
        end
        return result;
    endfunction

    task automatic add_step(input op_t op, input logic [addr_w-1:0] addr,
                            input logic [be_w-1:0] be, input logic [data_w-1:0] data,
                            input logic [data_w-1:0] exp);
        steps.push_back('{op, addr, be, data, exp});
    endtask

    task automatic step_clock();
        @(posedge clk);
        #1;
    endtask

    task automatic report_fault(input string what);
        $display("test %0d failed: %s", test_num, what);
        fault = 1'b1;
        step_clock();
        fault = 1'b0;
    endtask

    task automatic host_write(input step_t s);
        int t;
        wr_addr = s.addr;
        wr_be   = s.be;
        wr_data = s.data;
        wr_req  = 1'b1;
        step_clock();
        wr_req = 1'b0;
        t = 0;
        while (!wr_ack && t < 20) begin
            step_clock();
            t++;
        end
        if (!wr_ack) begin
            report_fault("no wr_ack after a write request");
        end
        // the converter model needs the configured frame length
        if (s.addr == addr_tx_bytes) begin
            frame_bytes = s.data[1:0];
        end
    endtask

    task automatic host_read(input logic [addr_w-1:0] addr, input logic armed,
                             input logic [data_w-1:0] exp, output logic [data_w-1:0] value);
        int t;
        rd_addr  = addr;
        rd_req   = 1'b1;
        check_rd = armed;
        exp_data = exp;
        step_clock();
        rd_req = 1'b0;
        t = 0;
        while (!rd_ack && t < 20) begin
            step_clock();
            t++;
        end
        value = rd_data;
        if (!rd_ack) begin
            report_fault("no rd_ack after a read request");
        end
        // checker compares on the edge that ends the ack cycle
        step_clock();
        check_rd = 1'b0;
    endtask

    task automatic wait_flag();
        logic [data_w-1:0] flag;
        int                t;
        flag = '0;
        t = 0;
        while (!flag[0] && t < 400) begin
            host_read(addr_rx_flag, 1'b0, '0, flag);
            t++;
        end
        if (!flag[0]) begin
            report_fault("rx flag never set after a frame");
        end
    endtask

    task automatic check_pins(input step_t s);
        pin_sel   = s.addr;
        exp_data  = s.exp;
        check_pin = 1'b1;
        step_clock();
        check_pin = 1'b0;
    endtask

    task automatic watch_quiet();
        quiet = 1'b1;
        repeat (500) step_clock();
        quiet = 1'b0;
        step_clock();
    endtask

    // ----------------------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------------------
    initial begin
        logic [data_w-1:0] word;
        logic [data_w-1:0] ra;
        logic [data_w-1:0] rb;
        logic [data_w-1:0] rc;
        logic [data_w-1:0] dummy;

        clk         = 1'b0;
        rst         = 1'b1;
        wr_addr     = '0;
        wr_req      = 1'b0;
        wr_be       = '0;
        wr_data     = '0;
        rd_addr     = '0;
        rd_req      = 1'b0;
        test_num    = 0;
        check_rd    = 1'b0;
        check_pin   = 1'b0;
        pin_sel     = '0;
        exp_data    = '0;
        quiet       = 1'b0;
        fault       = 1'b0;
        finish_run  = 1'b0;
        frame_bytes = 2'd3;
        rng         = 32'd10909;

        // reset values and read decode
        add_step(op_rd, addr_soft_reset, '0, '0, 32'd0);
        add_step(op_rd, addr_power_down, '0, '0, 32'd0);
        add_step(op_rd, addr_auto_spi, '0, '0, 32'd1);
        add_step(op_rd, addr_mux_sel, '0, '0, 32'd0);
        add_step(op_rd, addr_mux_en, '0, '0, 32'd0);
        add_step(op_rd, addr_tx_bytes, '0, '0, 32'd3);
        add_step(op_rd, addr_version, '0, '0, version_word);
        add_step(op_rd, 8'd12, '0, '0, bad_addr_word);

        // byte enables, sequencer held in soft reset so no frame starts
        add_step(op_wr, addr_auto_spi, 4'h1, 32'd0, '0);
        add_step(op_wr, addr_rx_flag, 4'h1, 32'd1, '0);
        add_step(op_wr, addr_soft_reset, 4'h1, 32'd1, '0);
        add_step(op_rd, addr_soft_reset, '0, '0, 32'd1);
        add_step(op_pin, addr_power_down, '0, '0, 32'd0);
        word = next_random();
        add_step(op_wr, addr_tx_data, 4'hf, word, '0);
        add_step(op_rd, addr_tx_data, '0, '0, word);
        ra = next_random();
        word = merge_bytes(word, ra, 4'b0101);
        add_step(op_wr, addr_tx_data, 4'b0101, ra, '0);
        add_step(op_rd, addr_tx_data, '0, '0, word);
        rb = next_random();
        word = merge_bytes(word, rb, 4'b1000);
        add_step(op_wr, addr_tx_data, 4'b1000, rb, '0);
        add_step(op_rd, addr_tx_data, '0, '0, word);
        add_step(op_wr, addr_soft_reset, 4'h1, 32'd0, '0);

        // manual frames, the model echoes the previous frame
        ra = next_random();
        add_step(op_wr, addr_tx_data, 4'hf, ra, '0);
        add_step(op_flag, '0, '0, '0, '0);
        add_step(op_rd, addr_rx_data, '0, '0, 32'd0);
        add_step(op_wr, addr_rx_flag, 4'h1, 32'd1, '0);
        add_step(op_rd, addr_rx_flag, '0, '0, 32'd0);
        rb = next_random();
        add_step(op_wr, addr_tx_data, 4'hf, rb, '0);
        add_step(op_flag, '0, '0, '0, '0);
        add_step(op_rd, addr_rx_data, '0, '0, ra);
        add_step(op_wr, addr_rx_flag, 4'h1, 32'd1, '0);

        // one-byte frame returns the low byte of the last one
        add_step(op_wr, addr_tx_bytes, 4'h1, 32'd0, '0);
        rc = next_random();
        add_step(op_wr, addr_tx_data, 4'hf, rc, '0);
        add_step(op_flag, '0, '0, '0, '0);
        add_step(op_rd, addr_rx_data, '0, '0, rb & 32'hff);
        add_step(op_wr, addr_rx_flag, 4'h1, 32'd1, '0);

        // mux pins, power-down, then auto frames of zero data
        add_step(op_wr, addr_mux_sel, 4'h1, 32'd5, '0);
        add_step(op_pin, addr_mux_sel, '0, '0, 32'd5);
        add_step(op_wr, addr_mux_en, 4'h1, 32'ha, '0);
        add_step(op_pin, addr_mux_en, '0, '0, 32'ha);
        add_step(op_wr, addr_power_down, 4'h1, 32'd1, '0);
        add_step(op_wr, addr_auto_spi, 4'h1, 32'd1, '0);
        add_step(op_pin, addr_power_down, '0, '0, 32'd0);
        add_step(op_quiet, '0, '0, '0, '0);
        add_step(op_wr, addr_power_down, 4'h1, 32'd0, '0);
        add_step(op_pin, addr_power_down, '0, '0, 32'd1);
        add_step(op_flag, '0, '0, '0, '0);
        add_step(op_rd, addr_rx_data, '0, '0, rc & 32'hff);
        add_step(op_wr, addr_rx_flag, 4'h1, 32'd1, '0);
        add_step(op_flag, '0, '0, '0, '0);
        add_step(op_rd, addr_rx_data, '0, '0, 32'd0);

        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        foreach (steps[i]) begin
            test_num = i;
            case (steps[i].op)
                op_wr:    host_write(steps[i]);
                op_rd:    host_read(steps[i].addr, 1'b1, steps[i].exp, dummy);
                op_flag:  wait_flag();
                op_pin:   check_pins(steps[i]);
                op_quiet: watch_quiet();
                default:  report_fault("unknown table operation");
            endcase
        end

        finish_run = 1'b1;
        step_clock();
        step_clock();
        if (fail_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: ads868x_checker.sv
// ADS868x response checker
`timescale 1ns/1ps
`default_nettype none

module ads868x_checker import ads868x_pkg::*; (
    input  var logic                 clk,
    input  var logic                 rst,
    // DUT ports under watch
    input  var logic                 wr_req,
    input  var logic                 wr_ack,
    input  var logic                 rd_req,
    input  var logic                 rd_ack,
    input  var logic [data_w-1:0]    rd_data,
    input  var logic                 sclk,
    input  var logic                 cs_n,
    input  var logic                 rst_pd_n,
    input  var logic [mux_sel_w-1:0] mux_sel,
    input  var logic [mux_en_w-1:0]  mux_en,
    // expectations from the stimulus loop
    input  var int                   test_num,
    input  var logic                 check_rd,
    input  var logic                 check_pin,
    input  var logic [addr_w-1:0]    pin_sel,
    input  var logic [data_w-1:0]    exp_data,
    input  var logic                 quiet,
    input  var logic                 fault,
    input  var logic                 finish_run,
    output var int                   fail_count
);

    int   pass_count = 0;
    int   errors = 0;
    int   active_cycles = 0;
    logic prev_wr_req = 1'b0;
    logic prev_rd_req = 1'b0;
    logic prev_quiet = 1'b0;
    logic prev_finish = 1'b0;

    assign fail_count = errors;

    task automatic compare(input string name, input logic [data_w-1:0] exp,
                           input logic [data_w-1:0] act);
        if (act === exp) begin
            pass_count++;
            $display("test %0d: %s ok (%h)", test_num, name, act);
        end else begin
            errors++;
            $display("** Error test %0d: %s expected %h, got %h", test_num, name, exp, act);
        end
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            // each ack trails its request by exactly one cycle
            if (wr_ack !== prev_wr_req) begin
                errors++;
                $display("** Error test %0d: wr_ack expected %h, got %h",
                         test_num, prev_wr_req, wr_ack);
            end
            if (rd_ack !== prev_rd_req) begin
                errors++;
                $display("** Error test %0d: rd_ack expected %h, got %h",
                         test_num, prev_rd_req, rd_ack);
            end
            if (check_rd && rd_ack) begin
                compare("rd_data", exp_data, rd_data);
            end
            if (check_pin) begin
                case (pin_sel)
                    addr_mux_sel: compare("mux_sel", exp_data, data_w'(mux_sel));
                    addr_mux_en:  compare("mux_en", exp_data, data_w'(mux_en));
                    default:      compare("rst_pd_n", exp_data, data_w'(rst_pd_n));
                endcase
            end
            // idle link keeps cs_n high and sclk low
            if (quiet && (cs_n !== 1'b1 || sclk !== 1'b0)) begin
                active_cycles++;
            end
            // quiet window just closed
            if (prev_quiet && !quiet) begin
                if (active_cycles == 0) begin
                    pass_count++;
                    $display("test %0d: no cs_n or sclk activity while powered down", test_num);
                end else begin
                    errors++;
                    $display("test %0d failed: cs_n or sclk active for %0d cycles in power-down",
                             test_num, active_cycles);
                end
                active_cycles = 0;
            end
            if (fault) begin
                errors++;
            end
        end
        if (finish_run && !prev_finish) begin
            $display("summary: %0d checks passed, %0d failed", pass_count, errors);
        end
        prev_wr_req <= wr_req;
        prev_rd_req <= rd_req;
        prev_quiet  <= quiet;
        prev_finish <= finish_run;
    end

endmodule

`default_nettype wire

// File: ads868x_adc_model.sv
// Behavioral ADS868x converter
`timescale 1ns/1ps
`default_nettype none

module ads868x_adc_model import ads868x_pkg::*; (
    input  var logic      sclk,
    input  var logic      cs_n,
    input  var logic      mosi,
    output var logic      miso,
    // frame length the host has configured
    input  var tx_bytes_t frame_bytes
);

    logic [data_w-1:0]    last_bits = '0;
    logic [data_w-1:0]    cur_bits = '0;
    int                   bit_idx = 0;
    int                   frame_len;
    logic [bit_cnt_w-1:0] pos;

    assign frame_len = 8 * (int'(frame_bytes) + 1);
    assign pos       = bit_cnt_w'(frame_len - 1 - bit_idx);

    // previous frame comes back right-aligned, msb first
    assign miso = (!cs_n && bit_idx < frame_len) ? last_bits[pos] : 1'b0;

    // mosi captured on rising sclk, frame kept when cs_n rises
    always @(posedge sclk or posedge cs_n) begin
        if (cs_n) begin
            last_bits <= cur_bits;
            cur_bits  <= '0;
        end else begin
            cur_bits <= {cur_bits[data_w-2:0], mosi};
        end
    end

    always @(negedge sclk or posedge cs_n) begin
        if (cs_n) begin
            bit_idx <= 0;
        end else begin
            bit_idx <= bit_idx + 1;
        end
    end

endmodule

`default_nettype wire

// File: ads868x_ctrl.sv
// ADS868x SPI controller top
`timescale 1ns/1ps
`default_nettype none

module ads868x_ctrl import ads868x_pkg::*; (
    input  var logic                 clk,
    input  var logic                 rst,
    // host port
    input  var logic [addr_w-1:0]    wr_addr,
    input  var logic                 wr_req,
    input  var logic [be_w-1:0]      wr_be,
    input  var logic [data_w-1:0]    wr_data,
    output var logic                 wr_ack,
    input  var logic [addr_w-1:0]    rd_addr,
    input  var logic                 rd_req,
    output var logic [data_w-1:0]    rd_data,
    output var logic                 rd_ack,
    // converter pins
    output var logic                 sclk,
    output var logic                 cs_n,
    output var logic                 mosi,
    input  var logic                 miso,
    output var logic                 rst_pd_n,
    // analog mux pins
    output var logic [mux_sel_w-1:0] mux_sel,
    output var logic [mux_en_w-1:0]  mux_en
);

    logic              ctrl_auto;
    logic              ctrl_soft_reset;
    logic              ctrl_power_down;
    tx_bytes_t         tx_bytes;
    logic [data_w-1:0] tx_data;
    logic              tx_strobe;
    logic [data_w-1:0] rxdata;
    logic              rxvalid;

    ads868x_spi_if spi_bus ();

    ads868x_regs u_regs (
        .clk             (clk),
        .rst             (rst),
        .wr_addr         (wr_addr),
        .wr_req          (wr_req),
        .wr_be           (wr_be),
        .wr_data         (wr_data),
        .wr_ack          (wr_ack),
        .rd_addr         (rd_addr),
        .rd_req          (rd_req),
        .rd_data         (rd_data),
        .rd_ack          (rd_ack),
        .ctrl_soft_reset (ctrl_soft_reset),
        .ctrl_power_down (ctrl_power_down),
        .ctrl_auto       (ctrl_auto),
        .mux_sel         (mux_sel),
        .mux_en          (mux_en),
        .tx_bytes        (tx_bytes),
        .tx_data         (tx_data),
        .tx_strobe       (tx_strobe),
        .rxdata          (rxdata),
        .rxvalid         (rxvalid)
    );

    ads868x_cmd_seq u_seq (
        .clk             (clk),
        .rst             (rst),
        .ctrl_auto       (ctrl_auto),
        .ctrl_power_down (ctrl_power_down),
        .ctrl_soft_reset (ctrl_soft_reset),
        .tx_bytes        (tx_bytes),
        .tx_data         (tx_data),
        .tx_strobe       (tx_strobe),
        .rxdata          (rxdata),
        .rxvalid         (rxvalid),
        .spi             (spi_bus.seq)
    );

    ads868x_spi_shifter u_shifter (
        .clk  (clk),
        .rst  (rst),
        .spi  (spi_bus.shifter),
        .sclk (sclk),
        .cs_n (cs_n),
        .mosi (mosi),
        .miso (miso)
    );

    // converter held in reset or power-down on either request
    assign rst_pd_n = !(ctrl_soft_reset || ctrl_power_down);

endmodule

`default_nettype wire

// File: ads868x_spi_shifter.sv
// SPI frame shifter, mode 0
`timescale 1ns/1ps
`default_nettype none

module ads868x_spi_shifter import ads868x_pkg::*; (
    input  var logic    clk,
    input  var logic    rst,
    ads868x_spi_if.shifter spi,
    output var logic    sclk,
    output var logic    cs_n,
    output var logic    mosi,
    input  var logic    miso
);

    typedef enum logic [1:0] {
        st_idle,
        st_setup,
        st_shift,
        st_hold
    } state_t;

    state_t                state;
    logic [sclk_div_w-1:0] div_cnt;
    logic [bit_cnt_w-1:0]  bit_cnt;
    logic [data_w-1:0]     tx_sr;
    logic [data_w-1:0]     rx_sr;
    logic                  half_done;

    assign half_done = div_cnt == sclk_div_w'(sclk_div - 1);

    // first frame bit sits at the top of the shift register
    assign mosi = tx_sr[data_w-1];

    // ----------------------------------------------------------------------
    // frame control
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= st_idle;
            div_cnt     <= '0;
            sclk        <= 1'b0;
            cs_n        <= 1'b1;
            spi.busy    <= 1'b0;
            spi.rxvalid <= 1'b0;
        end else begin
            spi.rxvalid <= 1'b0;
            case (state)
                st_idle: begin
                    if (spi.start) begin
                        state    <= st_setup;
                        cs_n     <= 1'b0;
                        spi.busy <= 1'b1;
                    end
                end
                st_setup: begin
                    state   <= st_shift;
                    div_cnt <= '0;
                end
                st_shift: begin
                    if (half_done) begin
                        div_cnt <= '0;
                        sclk    <= !sclk;
                        // falling edge of the last bit ends the frame
                        if (sclk && bit_cnt == '0) begin
                            state <= st_hold;
                        end
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end
                st_hold: begin
                    state       <= st_idle;
                    cs_n        <= 1'b1;
                    spi.busy    <= 1'b0;
                    spi.rxvalid <= 1'b1;
                end
                default: state <= st_idle;
            endcase
        end
    end

    // ----------------------------------------------------------------------
    // data path
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (state == st_idle && spi.start) begin
            // left-justify the low nbytes+1 bytes
            tx_sr   <= spi.txdata << {2'd3 - spi.nbytes, 3'b000};
            rx_sr   <= '0;
            bit_cnt <= {spi.nbytes, 3'b111};
        end else if (state == st_shift && half_done) begin
            if (!sclk) begin
                // rising edge, sample
                rx_sr <= {rx_sr[data_w-2:0], miso};
            end else if (bit_cnt != '0) begin
                // falling edge, next bit out
                tx_sr   <= tx_sr << 1;
                bit_cnt <= bit_cnt - 1'b1;
            end
        end
        if (state == st_hold) begin
            spi.rxdata <= rx_sr;
        end
    end

    busy_implies_selected: assert property (
        @(posedge clk) disable iff (rst) spi.busy |-> !cs_n
    );

endmodule

`default_nettype wire

// File: ads868x_cmd_seq.sv
// ADS868x frame command sequencer
`timescale 1ns/1ps
`default_nettype none

module ads868x_cmd_seq import ads868x_pkg::*; (
    input  var logic              clk,
    input  var logic              rst,
    input  var logic              ctrl_auto,
    input  var logic              ctrl_power_down,
    input  var logic              ctrl_soft_reset,
    input  var tx_bytes_t         tx_bytes,
    input  var logic [data_w-1:0] tx_data,
    input  var logic              tx_strobe,
    output var logic [data_w-1:0] rxdata,
    output var logic              rxvalid,
    ads868x_spi_if.seq            spi
);

    logic                  pending;
    tx_bytes_t             pend_bytes;
    logic [data_w-1:0]     pend_data;
    logic [auto_cnt_w-1:0] idle_cnt;
    logic                  auto_en;
    logic                  auto_due;
    logic                  can_start;
    logic                  launch_new;
    logic                  launch_pend;
    logic                  launch_auto;
    logic                  hold_new;

    assign auto_en  = ctrl_auto && !ctrl_power_down;
    assign auto_due = auto_en && idle_cnt == auto_cnt_w'(auto_period - 1);

    // shifter takes a new start only when idle and not just started
    assign can_start = !spi.busy && !spi.start && !ctrl_soft_reset;

    // priority: fresh write, then pending write, then auto frame
    assign launch_new  = tx_strobe && can_start;
    assign launch_pend = !tx_strobe && pending && can_start;
    assign launch_auto = !tx_strobe && !pending && auto_due && can_start;
    assign hold_new    = tx_strobe && !can_start && !ctrl_soft_reset;

    always_ff @(posedge clk) begin
        if (rst) begin
            spi.start <= 1'b0;
            pending   <= 1'b0;
            idle_cnt  <= '0;
        end else begin
            spi.start <= launch_new || launch_pend || launch_auto;
            if (ctrl_soft_reset || launch_new || launch_pend) begin
                pending <= 1'b0;
            end else if (hold_new) begin
                pending <= 1'b1;
            end
            // counts only while the link sits idle with auto enabled
            if (ctrl_soft_reset || !auto_en || pending || spi.busy || spi.start) begin
                idle_cnt <= '0;
            end else if (!auto_due) begin
                idle_cnt <= idle_cnt + 1'b1;
            end
        end
    end

    // command payload
    always_ff @(posedge clk) begin
        if (launch_new) begin
            spi.nbytes <= tx_bytes;
            spi.txdata <= tx_data;
        end else if (launch_pend) begin
            spi.nbytes <= pend_bytes;
            spi.txdata <= pend_data;
        end else if (launch_auto) begin
            spi.nbytes <= tx_bytes;
            spi.txdata <= '0;
        end
        if (hold_new) begin
            pend_bytes <= tx_bytes;
            pend_data  <= tx_data;
        end
    end

    // results pass straight on to the register file
    assign rxdata  = spi.rxdata;
    assign rxvalid = spi.rxvalid;

    start_only_when_idle: assert property (
        @(posedge clk) disable iff (rst) spi.start |-> !spi.busy
    );

endmodule

`default_nettype wire

// File: ads868x_regs.sv
// ADS868x host register file
`timescale 1ns/1ps
`default_nettype none

module ads868x_regs import ads868x_pkg::*; (
    input  var logic                 clk,
    input  var logic                 rst,
    // host write port
    input  var logic [addr_w-1:0]    wr_addr,
    input  var logic                 wr_req,
    input  var logic [be_w-1:0]      wr_be,
    input  var logic [data_w-1:0]    wr_data,
    output var logic                 wr_ack,
    // host read port
    input  var logic [addr_w-1:0]    rd_addr,
    input  var logic                 rd_req,
    output var logic [data_w-1:0]    rd_data,
    output var logic                 rd_ack,
    // control toward the sequencer and pins
    output var logic                 ctrl_soft_reset,
    output var logic                 ctrl_power_down,
    output var logic                 ctrl_auto,
    output var logic [mux_sel_w-1:0] mux_sel,
    output var logic [mux_en_w-1:0]  mux_en,
    output var tx_bytes_t            tx_bytes,
    output var logic [data_w-1:0]    tx_data,
    output var logic                 tx_strobe,
    // received frame result
    input  var logic [data_w-1:0]    rxdata,
    input  var logic                 rxvalid
);

    logic              wr_low;
    logic [data_w-1:0] rx_data;
    logic              rx_flag;

    // single-bit and narrow fields live in byte 0
    assign wr_low = wr_req && wr_be[0];

    // ----------------------------------------------------------------------
    // write side
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl_soft_reset <= 1'b0;
            ctrl_power_down <= 1'b0;
            ctrl_auto       <= 1'b1;
            mux_sel         <= '0;
            mux_en          <= '0;
            tx_bytes        <= 2'b11;
            tx_data         <= '0;
            tx_strobe       <= 1'b0;
            wr_ack          <= 1'b0;
        end else begin
            if (wr_low && wr_addr == addr_soft_reset) ctrl_soft_reset <= wr_data[0];
            if (wr_low && wr_addr == addr_power_down) ctrl_power_down <= wr_data[0];
            if (wr_low && wr_addr == addr_auto_spi)   ctrl_auto       <= wr_data[0];
            if (wr_low && wr_addr == addr_mux_sel)    mux_sel <= wr_data[mux_sel_w-1:0];
            if (wr_low && wr_addr == addr_mux_en)     mux_en  <= wr_data[mux_en_w-1:0];
            if (wr_low && wr_addr == addr_tx_bytes)   tx_bytes <= wr_data[1:0];
            for (int i = 0; i < be_w; i++) begin
                if (wr_req && wr_addr == addr_tx_data && wr_be[i]) begin
                    tx_data[i*8+7-:8] <= wr_data[i*8+7-:8];
                end
            end
            // launch request follows any tx_data write
            tx_strobe <= wr_req && wr_addr == addr_tx_data;
            wr_ack    <= wr_req;
        end
    end

    // ----------------------------------------------------------------------
    // receive latch and sticky flag
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_data <= '0;
            rx_flag <= 1'b0;
        end else begin
            if (rxvalid) begin
                rx_data <= rxdata;
            end
            // a new word wins over a clear in the same cycle
            if (rxvalid) begin
                rx_flag <= 1'b1;
            end else if (wr_low && wr_addr == addr_rx_flag && wr_data[0]) begin
                rx_flag <= 1'b0;
            end
        end
    end

    // ----------------------------------------------------------------------
    // read side
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_data <= '0;
            rd_ack  <= 1'b0;
        end else begin
            rd_ack <= rd_req;
            if (rd_req) begin
                case (rd_addr)
                    addr_soft_reset: rd_data <= data_w'(ctrl_soft_reset);
                    addr_power_down: rd_data <= data_w'(ctrl_power_down);
                    addr_auto_spi:   rd_data <= data_w'(ctrl_auto);
                    addr_mux_sel:    rd_data <= data_w'(mux_sel);
                    addr_mux_en:     rd_data <= data_w'(mux_en);
                    addr_tx_bytes:   rd_data <= data_w'(tx_bytes);
                    addr_tx_data:    rd_data <= tx_data;
                    addr_rx_data:    rd_data <= rx_data;
                    addr_rx_flag:    rd_data <= data_w'(rx_flag);
                    addr_version:    rd_data <= version_word;
                    default:         rd_data <= bad_addr_word;
                endcase
            end
        end
    end

    // host handshake is strictly one request, one ack
    wr_ack_follows_req: assert property (
        @(posedge clk) disable iff (rst) $rose(wr_ack) |-> $past(wr_req)
    );

endmodule

`default_nettype wire

// File: ads868x_spi_if.sv
// SPI frame command interface
`timescale 1ns/1ps
`default_nettype none

interface ads868x_spi_if import ads868x_pkg::*; ();

    // command toward the shifter
    logic              start;
    tx_bytes_t         nbytes;
    logic [data_w-1:0] txdata;

    // status and result back from the shifter
    logic              busy;
    logic [data_w-1:0] rxdata;
    logic              rxvalid;

    modport seq (
        output start, nbytes, txdata,
        input  busy, rxdata, rxvalid
    );

    modport shifter (
        input  start, nbytes, txdata,
        output busy, rxdata, rxvalid
    );

endinterface

`default_nettype wire

// File: ads868x_pkg.sv
// ADS868x controller definitions
`default_nettype none

package ads868x_pkg;

    // ----------------------------------------------------------------------
    // bus widths
    // ----------------------------------------------------------------------
    localparam int addr_w    = 8;
    localparam int data_w    = 32;
    localparam int be_w      = data_w / 8;
    localparam int mux_sel_w = 3;
    localparam int mux_en_w  = 4;

    // ----------------------------------------------------------------------
    // register map
    // ----------------------------------------------------------------------
    localparam logic [addr_w-1:0] addr_soft_reset = 8'd0;
    localparam logic [addr_w-1:0] addr_power_down = 8'd1;
    localparam logic [addr_w-1:0] addr_auto_spi   = 8'd2;
    localparam logic [addr_w-1:0] addr_mux_sel    = 8'd3;
    localparam logic [addr_w-1:0] addr_mux_en     = 8'd4;
    localparam logic [addr_w-1:0] addr_tx_bytes   = 8'd5;
    localparam logic [addr_w-1:0] addr_tx_data    = 8'd6;
    localparam logic [addr_w-1:0] addr_rx_data    = 8'd7;
    localparam logic [addr_w-1:0] addr_rx_flag    = 8'd8;
    localparam logic [addr_w-1:0] addr_version    = 8'd9;

    localparam logic [data_w-1:0] version_word  = 32'h0001_0200;
    localparam logic [data_w-1:0] bad_addr_word = 32'hDEAD_BEEF;

    // ----------------------------------------------------------------------
    // timing
    // ----------------------------------------------------------------------
    // system clocks per half sclk period
    localparam int sclk_div    = 4;
    localparam int sclk_div_w  = $clog2(sclk_div);
    // idle clocks between end of one auto frame and the next start
    localparam int auto_period = 64;
    localparam int auto_cnt_w  = $clog2(auto_period);
    localparam int bit_cnt_w   = $clog2(data_w);

    // frame length in bytes minus one
    typedef logic [1:0] tx_bytes_t;

endpackage

`default_nettype wire
